//--- common/rob_pkg.sv
`default_nettype none

package rob_pkg;

  // ============================================================
  // Sizes
  // ============================================================
  localparam int ROB_ENTRIES = 16;
  localparam int VLEN_BYTES  = 16;

  // ============================================================
  // Widths that carry a meaning
  // ============================================================
  typedef logic [3:0]   rob_tag_t;
  // Extra top bit tells full from empty
  typedef logic [4:0]   rob_ptr_t;
  typedef logic [4:0]   vreg_t;
  typedef logic [127:0] vdata_t;
  typedef logic [15:0]  byte_ena_t;
  // Element 0 in bits 31:0, element 1 in bits 63:32
  typedef logic [63:0]  beat_data_t;
  typedef logic [6:0]   elem_off_t;
  typedef logic [7:0]   vl_t;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [1:0] {
    LMUL1 = 2'd0,
    LMUL2 = 2'd1,
    LMUL4 = 2'd2,
    LMUL8 = 2'd3
  } lmul_t;

  // ============================================================
  // Structs
  // ============================================================
  typedef struct packed {
    logic       ready;
    rob_tag_t   index;
    vreg_t      vd;
    sew_t       sew;
    elem_off_t  woffset;
    vl_t        vl;
    beat_data_t wdata;
    logic [1:0] elem_en;
  } result_beat_t;

  typedef struct packed {
    rob_tag_t   final_index;
    vreg_t      final_vd;
    logic [3:0] byte_off;
    logic       filled;
    logic       last;
  } beat_loc_t;

  typedef struct packed {
    logic      wen;
    vreg_t     vd;
    byte_ena_t byte_ena;
    vdata_t    data;
  } vreg_write_t;

  // Element size in bytes
  function automatic logic [2:0] sew_bytes(input sew_t sew);
    case (sew)
      SEW32:   return 3'd4;
      SEW16:   return 3'd2;
      default: return 3'd1;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- rob/rob_pointers.sv
`timescale 1ns/10ps
`default_nettype none

module rob_pointers (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             alloc_ena,
  input  logic             commit,
  input  logic             flush,
  input  rob_pkg::lmul_t   lmul,
  output rob_pkg::rob_tag_t head_index,
  output rob_pkg::rob_tag_t cur_tail,
  output logic             full,
  output logic             alloc_ok
);
  import rob_pkg::*;

  rob_ptr_t head;
  rob_ptr_t tail;
  rob_ptr_t occupancy;
  rob_ptr_t free_count;
  rob_ptr_t group_size;

  // Wrap bits make the difference exact up to ROB_ENTRIES
  assign occupancy  = tail - head;
  assign free_count = rob_ptr_t'(ROB_ENTRIES) - occupancy;
  assign full       = (occupancy == rob_ptr_t'(ROB_ENTRIES));

  // One entry per register of the group
  always_comb begin
    case (lmul)
      LMUL2:   group_size = 5'd2;
      LMUL4:   group_size = 5'd4;
      LMUL8:   group_size = 5'd8;
      default: group_size = 5'd1;
    endcase
  end

  assign alloc_ok   = alloc_ena && (free_count >= group_size);
  assign head_index = head[3:0];
  assign cur_tail   = tail[3:0];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else if (flush) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (commit) begin
        head <= head + 5'd1;
      end
      // Refused requests leave the tail alone
      if (alloc_ok) begin
        tail <= tail + group_size;
      end
    end
  end

endmodule

`default_nettype wire

//--- rob/entry_locator.sv
`timescale 1ns/10ps
`default_nettype none

module entry_locator (
  input  rob_pkg::result_beat_t beat,
  output rob_pkg::beat_loc_t    loc
);
  import rob_pkg::*;

  logic [2:0] size;
  logic [8:0] byte_pos;
  logic [4:0] entry_step;
  logic [3:0] byte_off;
  logic [4:0] beat_end;
  vl_t        next_elem;
  rob_tag_t   final_index;
  vreg_t      final_vd;
  logic       filled;
  logic       last;

  // ============================================================
  // Byte position of element 0 within the group
  // ============================================================
  assign size     = sew_bytes(beat.sew);
  assign byte_pos = {2'b00, beat.woffset} * {6'd0, size};

  // Upper bits pick the entry, lower bits the byte in it
  assign entry_step = byte_pos[8:4];
  assign byte_off   = byte_pos[3:0];

  // Entry index wraps around the buffer
  assign final_index = beat.index + entry_step[3:0];
  assign final_vd    = beat.vd + entry_step;

  // Both elements fit in the entry since woffset is even
  assign beat_end = {1'b0, byte_off} + {1'b0, size, 1'b0};
  assign filled   = (beat_end == 5'(VLEN_BYTES));

  // Final beat of the instruction including odd vl
  assign next_elem = {1'b0, beat.woffset} + 8'd2;
  assign last      = (next_elem >= beat.vl);

  assign loc = '{
    final_index: final_index,
    final_vd:    final_vd,
    byte_off:    byte_off,
    filled:      filled,
    last:        last
  };

endmodule

`default_nettype wire

//--- rob/rob_entry_array.sv
`timescale 1ns/10ps
`default_nettype none

module rob_entry_array #(
  parameter int NUM_RESULT_PORTS = 2
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  rob_pkg::result_beat_t results [NUM_RESULT_PORTS],
  input  rob_pkg::beat_loc_t    locs [NUM_RESULT_PORTS],
  input  rob_pkg::rob_tag_t     head_index,
  input  logic                  commit_ena,
  input  logic                  flush,
  output logic                  commit,
  output rob_pkg::vreg_write_t  vreg_wr
);
  import rob_pkg::*;

  // A beat already shifted to its byte position in the entry
  typedef struct packed {
    byte_ena_t mask;
    byte_ena_t ena;
    vdata_t    data;
  } placed_beat_t;

  logic [ROB_ENTRIES-1:0] valid_q;
  byte_ena_t              ena_q  [ROB_ENTRIES];
  vreg_t                  vd_q   [ROB_ENTRIES];
  vdata_t                 data_q [ROB_ENTRIES];
  placed_beat_t           placed [NUM_RESULT_PORTS];

  // ============================================================
  // Element extraction and placement per port
  // ============================================================
  for (genvar p = 0; p < NUM_RESULT_PORTS; p++) begin : g_place
    result_beat_t beat;
    logic         e0_en;
    logic         e1_en;
    beat_data_t   lane_data;
    logic [7:0]   lane_mask;
    logic [7:0]   lane_ena;

    assign beat  = results[p];
    assign e0_en = beat.elem_en[0];
    // Odd vl leaves the last beat without element 1
    assign e1_en = beat.elem_en[1] & ({1'b0, beat.woffset} != beat.vl - 8'd1);

    always_comb begin
      case (beat.sew)
        SEW32: begin
          lane_data = beat.wdata;
          lane_mask = 8'hff;
          lane_ena  = {{4{e1_en}}, {4{e0_en}}};
        end
        SEW16: begin
          lane_data = {32'd0, beat.wdata[47:32], beat.wdata[15:0]};
          lane_mask = 8'h0f;
          lane_ena  = {4'd0, {2{e1_en}}, {2{e0_en}}};
        end
        default: begin
          lane_data = {48'd0, beat.wdata[39:32], beat.wdata[7:0]};
          lane_mask = 8'h03;
          lane_ena  = {6'd0, e1_en, e0_en};
        end
      endcase
    end

    assign placed[p] = '{
      mask: byte_ena_t'(lane_mask) << locs[p].byte_off,
      ena:  byte_ena_t'(lane_ena) << locs[p].byte_off,
      data: vdata_t'(lane_data) << {locs[p].byte_off, 3'b000}
    };
  end

  // ============================================================
  // Head commit
  // ============================================================
  assign commit = commit_ena & valid_q[head_index];

  assign vreg_wr = '{
    wen:      commit,
    vd:       vd_q[head_index],
    byte_ena: ena_q[head_index],
    data:     data_q[head_index]
  };

  // Valid and byte enables are cleared on commit and flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
      for (int i = 0; i < ROB_ENTRIES; i++) begin
        ena_q[i] <= '0;
      end
    end else if (flush) begin
      valid_q <= '0;
      for (int i = 0; i < ROB_ENTRIES; i++) begin
        ena_q[i] <= '0;
      end
    end else begin
      if (commit) begin
        valid_q[head_index] <= 1'b0;
        ena_q[head_index]   <= '0;
      end
      // Ports never share an entry in one cycle
      for (int p = 0; p < NUM_RESULT_PORTS; p++) begin
        if (results[p].ready) begin
          valid_q[locs[p].final_index] <= locs[p].filled | locs[p].last;
          ena_q[locs[p].final_index]   <= (ena_q[locs[p].final_index] & ~placed[p].mask)
                                          | placed[p].ena;
        end
      end
    end
  end

  // Payload writes only the bytes the beat covers
  always_ff @(posedge CLK) begin
    for (int p = 0; p < NUM_RESULT_PORTS; p++) begin
      if (results[p].ready) begin
        vd_q[locs[p].final_index] <= locs[p].final_vd;
        for (int b = 0; b < VLEN_BYTES; b++) begin
          if (placed[p].mask[b]) begin
            data_q[locs[p].final_index][b*8 +: 8] <= placed[p].data[b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/vector_rob.sv
`timescale 1ns/10ps
`default_nettype none

module vector_rob #(
  parameter int NUM_RESULT_PORTS = 2
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  alloc_ena,
  input  rob_pkg::lmul_t        lmul,
  input  logic                  commit_ena,
  input  logic                  flush,
  // Port 0 is arith, port 1 is load-store
  input  rob_pkg::result_beat_t results [NUM_RESULT_PORTS],
  output rob_pkg::rob_tag_t     cur_tail,
  output logic                  full,
  output logic                  alloc_ok,
  output rob_pkg::vreg_write_t  vreg_wr
);
  import rob_pkg::*;

  rob_tag_t  head_index;
  logic      commit;
  beat_loc_t locs [NUM_RESULT_PORTS];

  rob_pointers u_pointers (
    .CLK        (CLK),
    .nRST       (nRST),
    .alloc_ena  (alloc_ena),
    .commit     (commit),
    .flush      (flush),
    .lmul       (lmul),
    .head_index (head_index),
    .cur_tail   (cur_tail),
    .full       (full),
    .alloc_ok   (alloc_ok)
  );

  for (genvar p = 0; p < NUM_RESULT_PORTS; p++) begin : g_locator
    entry_locator u_locator (
      .beat (results[p]),
      .loc  (locs[p])
    );
  end

  rob_entry_array #(
    .NUM_RESULT_PORTS (NUM_RESULT_PORTS)
  ) u_entries (
    .CLK        (CLK),
    .nRST       (nRST),
    .results    (results),
    .locs       (locs),
    .head_index (head_index),
    .commit_ena (commit_ena),
    .flush      (flush),
    .commit     (commit),
    .vreg_wr    (vreg_wr)
  );

endmodule

`default_nettype wire

//--- testbench/tb_vector_rob.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vector_rob;
  import rob_pkg::*;

  localparam int NUM_PORTS = 2;
  localparam int PERIOD    = 40;
  localparam int MAX_SEQ   = 2048;
  localparam int TEST_CYCLES = 2 + 40 + 140 + 1 + 8 + 600 + 300;

  logic         CLK, nRST, alloc_ena, commit_ena, flush, full, alloc_ok;
  lmul_t        lmul;
  result_beat_t results [NUM_PORTS];
  rob_tag_t     cur_tail;
  vreg_write_t  vreg_wr;

  // ============================================================
  // Reference model state
  // ============================================================
  integer       seed;
  int           errors, checks, head_seq, alloc_seq, tail, num_groups;
  vreg_t        exp_vd   [MAX_SEQ];
  byte_ena_t    exp_ena  [MAX_SEQ];
  vdata_t       exp_data [MAX_SEQ];
  logic         exp_done [MAX_SEQ];
  int           g_seq [MAX_SEQ], g_tag [MAX_SEQ], g_vl [MAX_SEQ], g_next [MAX_SEQ];
  sew_t         g_sew [MAX_SEQ];
  vreg_t        g_vd  [MAX_SEQ];
  int           pending [$];
  result_beat_t issued [NUM_PORTS];
  int           issued_grp [NUM_PORTS];

  vector_rob #(.NUM_RESULT_PORTS(NUM_PORTS)) DUT (
    .CLK(CLK), .nRST(nRST), .alloc_ena(alloc_ena), .lmul(lmul), .commit_ena(commit_ena),
    .flush(flush), .results(results), .cur_tail(cur_tail), .full(full),
    .alloc_ok(alloc_ok), .vreg_wr(vreg_wr)
  );

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int elem_size(input sew_t s);
    case (s)
      SEW32:   return 4;
      SEW16:   return 2;
      default: return 1;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %0h expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  // vl always reaches the last register so every entry of the group completes
  task automatic open_group(input lmul_t lm);
    int g, regs, epr, lo;
    g = num_groups;
    regs = 1 << int'(lm);
    g_sew[g] = sew_t'(rand_below(3));
    epr = VLEN_BYTES / elem_size(g_sew[g]);
    lo = (regs - 1) * epr + 1;
    g_vl[g] = lo + rand_below(regs * epr - lo + 1);
    g_vd[g] = vreg_t'(rand_below(32));
    g_seq[g] = alloc_seq;
    g_tag[g] = tail;
    g_next[g] = 0;
    for (int j = 0; j < regs; j++) begin
      exp_vd[alloc_seq + j] = g_vd[g] + vreg_t'(j);
      exp_ena[alloc_seq + j] = '0;
      exp_data[alloc_seq + j] = '0;
      exp_done[alloc_seq + j] = 1'b0;
    end
    alloc_seq += regs;
    tail = (tail + regs) % ROB_ENTRIES;
    num_groups++;
    pending.push_back(g);
  endtask

  function automatic result_beat_t make_beat(input int g);
    result_beat_t bt;
    bt.ready   = 1'b1;
    bt.index   = rob_tag_t'(g_tag[g]);
    bt.vd      = g_vd[g];
    bt.sew     = g_sew[g];
    bt.woffset = elem_off_t'(g_next[g]);
    bt.vl      = vl_t'(g_vl[g]);
    bt.wdata   = {$random(seed), $random(seed)};
    bt.elem_en = 2'(rand_below(4));
    return bt;
  endfunction

  // Element e of size s lands at byte e*s of the group
  task automatic apply_beat(input result_beat_t bt, input int g);
    int s, e, pos, seq, off;
    s = elem_size(bt.sew);
    for (int k = 0; k < 2; k++) begin
      e = int'(bt.woffset) + k;
      if (e < g_vl[g]) begin
        pos = e * s;
        seq = g_seq[g] + pos / VLEN_BYTES;
        off = pos % VLEN_BYTES;
        for (int b = 0; b < s; b++) begin
          exp_data[seq][(off + b) * 8 +: 8] = bt.wdata[k * 32 + b * 8 +: 8];
          exp_ena[seq][off + b] = bt.elem_en[k];
        end
      end
    end
    pos = int'(bt.woffset) * s;
    if (pos % VLEN_BYTES + 2 * s == VLEN_BYTES || int'(bt.woffset) + 2 >= g_vl[g]) begin
      exp_done[g_seq[g] + pos / VLEN_BYTES] = 1'b1;
    end
  endtask

  // Outputs are stable at the falling edge; model steps to the next rising edge
  task automatic check_cycle();
    logic   exp_wen, exp_ok;
    int     occ;
    vdata_t mask;
    occ = alloc_seq - head_seq;
    exp_wen = commit_ena && (occ > 0) && exp_done[head_seq];
    exp_ok = alloc_ena && (ROB_ENTRIES - occ >= (1 << int'(lmul)));
    check_val("vreg_wr.wen", vreg_wr.wen, exp_wen);
    check_val("alloc_ok", alloc_ok, exp_ok);
    check_val("full", full, occ == ROB_ENTRIES);
    check_val("cur_tail", cur_tail, tail);
    if (vreg_wr.wen && exp_wen) begin
      for (int b = 0; b < VLEN_BYTES; b++) begin
        mask[b * 8 +: 8] = {8{exp_ena[head_seq][b]}};
      end
      check_val("vreg_wr.vd", vreg_wr.vd, exp_vd[head_seq]);
      check_val("vreg_wr.byte_ena", vreg_wr.byte_ena, exp_ena[head_seq]);
      check_val("vreg_wr.data", vreg_wr.data & mask, exp_data[head_seq] & mask);
    end
    if (exp_wen) begin
      head_seq++;
    end
    if (exp_ok) begin
      open_group(lmul);
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (issued_grp[p] >= 0) begin
        apply_beat(issued[p], issued_grp[p]);
      end
    end
  endtask

  task automatic run_cycles(input int n, input int alloc_pct, input int commit_pct,
                            input int beat_pct);
    int avail [$];
    int k, g;
    for (int c = 0; c < n; c++) begin
      @(posedge CLK);
      alloc_ena  <= (rand_below(100) < alloc_pct);
      lmul       <= lmul_t'(rand_below(4));
      commit_ena <= (rand_below(100) < commit_pct);
      flush      <= 1'b0;
      avail = pending;
      // Each port serves its own group and beats of a group stay in order
      for (int p = 0; p < NUM_PORTS; p++) begin
        issued_grp[p] = -1;
        results[p] <= '0;
        if (avail.size() > 0 && rand_below(100) < beat_pct) begin
          k = rand_below(avail.size());
          g = avail[k];
          avail.delete(k);
          issued[p] = make_beat(g);
          issued_grp[p] = g;
          results[p] <= issued[p];
          g_next[g] += 2;
        end
      end
      for (int i = pending.size() - 1; i >= 0; i--) begin
        if (g_next[pending[i]] >= g_vl[pending[i]]) begin
          pending.delete(i);
        end
      end
      @(negedge CLK);
      check_cycle();
    end
  endtask

  task automatic pulse_flush();
    @(posedge CLK);
    alloc_ena  <= 1'b0;
    commit_ena <= 1'b1;
    flush      <= 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      issued_grp[p] = -1;
      results[p] <= '0;
    end
    @(negedge CLK);
    check_cycle();
    head_seq = alloc_seq;
    tail = 0;
    pending.delete();
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    seed = 78;
    {errors, checks, head_seq, alloc_seq, tail, num_groups} = '0;
    {nRST, alloc_ena, flush} = '0;
    // A commit request during reset finds no valid head
    commit_ena = 1'b1;
    lmul = LMUL1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      results[p] = '0;
      issued_grp[p] = -1;
    end
    @(posedge CLK);
    @(negedge CLK);
    check_val("vreg_wr.wen", vreg_wr.wen, 1'b0);
    check_val("full", full, 1'b0);
    check_val("cur_tail", cur_tail, 0);
    @(posedge CLK);
    nRST <= 1'b1;
    // Back-pressure with no commits, then fill entries and flush them
    run_cycles(40, 100, 0, 0);
    if (alloc_seq - head_seq != ROB_ENTRIES) begin
      errors++;
      $display("allocation phase never filled the buffer, %0d entries used",
               alloc_seq - head_seq);
    end
    run_cycles(140, 0, 0, 100);
    pulse_flush();
    run_cycles(8, 0, 100, 0);
    // Mixed traffic, then drain
    run_cycles(600, 40, 60, 75);
    run_cycles(300, 0, 100, 100);
    if (pending.size() != 0 || head_seq != alloc_seq) begin
      errors++;
      $display("buffer did not drain, %0d entries left", alloc_seq - head_seq);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #((TEST_CYCLES + 200) * PERIOD);
    $display("watchdog expired after %0d cycles", TEST_CYCLES + 200);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
common/rob_pkg.sv
rob/rob_pointers.sv
rob/entry_locator.sv
rob/rob_entry_array.sv
src/vector_rob.sv
testbench/tb_vector_rob.sv

//--- Bender.yml
package:
  name: vector_rob

sources:
  - common/rob_pkg.sv
  - rob/rob_pointers.sv
  - rob/entry_locator.sv
  - rob/rob_entry_array.sv
  - src/vector_rob.sv
  - target: test
    files:
      - testbench/tb_vector_rob.sv
